/* hdl/adc_acq_pkg.sv */
/*
 * shared widths and enums for the acquisition side on adc_sm_clk
 * sample_t holds a raw converter word or a two's complement CDS difference
 * period_t counts adc_sm_clk cycles, so 16 bits covers about 3.2 ms at 20 MHz
 */
`default_nettype none

package adc_acq_pkg;

    localparam int ADC_BITS = 16;                // AD7685 word length

    typedef logic [ADC_BITS-1:0] sample_t;       // raw result or cds difference
    typedef logic [15:0]         period_t;       // cycle counts for timer and strobes
    typedef logic [7:0]          ovr_cnt_t;      // skipped request counter, saturating

    typedef enum logic {
        ACQ_VOLT = 1'b0,                         // pass each result through
        ACQ_CDS  = 1'b1                          // second minus first per window
    } acq_mode_e;

    typedef enum logic [2:0] {
        ST_IDLE,                                 // stopped, mode may change
        ST_VOLT,                                 // voltage mode running
        ST_CDS_FIRST,                            // waiting for first result of pair
        ST_CDS_SECOND,                           // waiting for second result
        ST_CDS_SUB                               // forming the difference
    } acq_state_e;

endpackage

`default_nettype wire

/* hdl/adc_conv_if.sv */
/*
 * request and result path between acq_ctrl and the serial converter controller
 * start may only pulse while busy is low
 * busy rises the cycle after start and falls on the result_valid cycle
 */
`timescale 1ns/1ns
`default_nettype none

interface adc_conv_if;
    import adc_acq_pkg::*;

    logic    start;         // one-cycle conversion request
    logic    busy;          // conversion or readout in progress
    sample_t result;        // shifted-in converter word
    logic    result_valid;  // one-cycle strobe, result is complete

    modport ctrl (output start, input busy, input result, input result_valid);
    modport conv (input start, output busy, output result, output result_valid);

endinterface

`default_nettype wire

/* hdl/sample_timer.sv */
/*
 * voltage-mode request source
 * a rising edge of int_reset_i with start_meas_i high restarts the period count
 * and gives a frame pulse one cycle later, then one every period_i cycles
 * period_i must be at least 2, SETTLE_CYCLES at least 2
 * frame_req_o is the frame pulse delayed by exactly SETTLE_CYCLES
 */
`timescale 1ns/1ns
`default_nettype none

module sample_timer #(
    parameter int SETTLE_CYCLES = 160
) (
    input  logic                 adc_sm_clk,
    input  logic                 adc_sm_rst,
    input  logic                 start_meas_i,
    input  logic                 int_reset_i,
    input  adc_acq_pkg::period_t period_i,
    output logic                 frame_req_o
);
    import adc_acq_pkg::*;

    logic                     int_reset_q;   // previous int_reset_i for edge detect
    logic                     reset_rise;
    logic                     running_q;     // period counter armed
    period_t                  period_cnt_q;
    logic                     frame_q;       // frame pulse, before settling
    logic [SETTLE_CYCLES-1:0] settle_q;      // one bit per cycle of settling

    assign reset_rise = int_reset_i & ~int_reset_q;

    always_ff @(posedge adc_sm_clk) begin
        if (adc_sm_rst) begin
            int_reset_q  <= 1'b0;
            running_q    <= 1'b0;
            period_cnt_q <= '0;
            frame_q      <= 1'b0;
        end else begin
            int_reset_q <= int_reset_i;
            frame_q     <= 1'b0;
            if (!start_meas_i) begin
                running_q <= 1'b0;                       // stop making new frames
            end else if (reset_rise) begin
                running_q    <= 1'b1;                    // restart phase on every edge
                period_cnt_q <= '0;
                frame_q      <= 1'b1;
            end else if (running_q) begin
                if (period_cnt_q == period_i - period_t'(1)) begin
                    period_cnt_q <= '0;
                    frame_q      <= 1'b1;
                end else begin
                    period_cnt_q <= period_cnt_q + period_t'(1);
                end
            end
        end
    end

    // settling delay, several frames may be in flight when the period is short
    always_ff @(posedge adc_sm_clk) begin
        if (adc_sm_rst) begin
            settle_q <= '0;
        end else begin
            settle_q <= {settle_q[SETTLE_CYCLES-2:0], frame_q};
        end
    end

    assign frame_req_o = settle_q[SETTLE_CYCLES-1];

endmodule

`default_nettype wire

/* hdl/cds_strobe_gen.sv */
/*
 * software CDS strobes, two per integration window
 * first strobe comes cds_delay1_i cycles after the int_reset_i rising edge,
 * second one cds_delay2_i cycles after the first, both delays at least 1
 * a new rising edge cancels a pair that has not finished
 * cds_second_o is only meaningful while cds_req_o is high
 */
`timescale 1ns/1ns
`default_nettype none

module cds_strobe_gen (
    input  logic                 adc_sm_clk,
    input  logic                 adc_sm_rst,
    input  logic                 int_reset_i,
    input  adc_acq_pkg::period_t cds_delay1_i,
    input  adc_acq_pkg::period_t cds_delay2_i,
    output logic                 cds_req_o,
    output logic                 cds_second_o
);
    import adc_acq_pkg::*;

    logic    int_reset_q;
    logic    reset_rise;
    logic    active_q;       // a pair is being sequenced
    logic    second_q;       // counting towards the second strobe
    period_t delay_cnt_q;    // shared down-counter for both delays
    logic    strobe;

    assign reset_rise = int_reset_i & ~int_reset_q;
    assign strobe     = active_q & (delay_cnt_q == period_t'(1));

    always_ff @(posedge adc_sm_clk) begin
        if (adc_sm_rst) begin
            int_reset_q <= 1'b0;
            active_q    <= 1'b0;
            second_q    <= 1'b0;
            delay_cnt_q <= '0;
        end else begin
            int_reset_q <= int_reset_i;
            if (reset_rise) begin
                active_q    <= 1'b1;          // new window, drop whatever was pending
                second_q    <= 1'b0;
                delay_cnt_q <= cds_delay1_i;
            end else if (strobe) begin
                if (second_q) begin
                    active_q <= 1'b0;         // pair done
                end else begin
                    second_q    <= 1'b1;
                    delay_cnt_q <= cds_delay2_i;
                end
            end else if (active_q) begin
                delay_cnt_q <= delay_cnt_q - period_t'(1);
            end
        end
    end

    assign cds_req_o    = strobe;
    assign cds_second_o = second_q;

endmodule

`default_nettype wire

/* hdl/adc_serial_ctrl.sv */
/*
 * AD7685-style readout, 3-wire mode without busy indicator
 * CNV high for CONV_CYCLES cycles from the cycle after start, CONV_CYCLES >= 1
 * then 16 SCK periods of two cycles, SCK high first, MSB first
 * SDO is captured on the clock edge that raises SCK, so the converter bit
 * must be stable before SCK rises
 * start to result_valid is CONV_CYCLES + 33 cycles
 */
`timescale 1ns/1ns
`default_nettype none

module adc_serial_ctrl #(
    parameter int CONV_CYCLES = 45
) (
    input  logic     adc_sm_clk,
    input  logic     adc_sm_rst,
    input  logic     adc_sdo_i,
    output logic     adc_cnv_o,
    output logic     adc_sck_o,
    adc_conv_if.conv conv
);
    import adc_acq_pkg::*;

    localparam int CYC_W = $clog2(CONV_CYCLES + 1);
    localparam int BIT_W = $clog2(ADC_BITS);

    typedef enum logic [1:0] {
        S_IDLE,
        S_CONV,      // CNV high, converter busy internally
        S_SHIFT,     // clocking out the word
        S_DONE       // result valid, may start again
    } ser_state_e;

    ser_state_e       state_q;
    logic [CYC_W-1:0] cyc_q;      // cycles of CNV high so far
    logic [BIT_W-1:0] bit_q;      // bits captured minus one
    logic             cnv_q;
    logic             sck_q;
    sample_t          shift_q;
    logic             cyc_last;
    logic             bit_last;
    logic             take_bit;

    assign cyc_last = (cyc_q == CYC_W'(CONV_CYCLES - 1));
    assign bit_last = (bit_q == BIT_W'(ADC_BITS - 1));

    // capture on every edge that drives SCK from low to high
    assign take_bit = ((state_q == S_CONV) & cyc_last) |
                      ((state_q == S_SHIFT) & ~sck_q & ~bit_last);

    always_ff @(posedge adc_sm_clk) begin
        if (adc_sm_rst) begin
            state_q <= S_IDLE;
            cyc_q   <= '0;
            bit_q   <= '0;
            cnv_q   <= 1'b0;
            sck_q   <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE, S_DONE: begin
                    state_q <= S_IDLE;
                    if (conv.start) begin
                        state_q <= S_CONV;
                        cnv_q   <= 1'b1;
                        cyc_q   <= '0;
                    end
                end
                S_CONV: begin
                    if (cyc_last) begin
                        state_q <= S_SHIFT;
                        cnv_q   <= 1'b0;
                        sck_q   <= 1'b1;      // first rising edge, MSB taken
                        bit_q   <= '0;
                    end else begin
                        cyc_q <= cyc_q + 1'b1;
                    end
                end
                S_SHIFT: begin
                    if (sck_q) begin
                        sck_q <= 1'b0;
                    end else if (bit_last) begin
                        state_q <= S_DONE;    // last falling edge already done
                    end else begin
                        sck_q <= 1'b1;
                        bit_q <= bit_q + 1'b1;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge adc_sm_clk) begin
        if (take_bit) begin
            shift_q <= {shift_q[ADC_BITS-2:0], adc_sdo_i};
        end
    end

    assign adc_cnv_o         = cnv_q;
    assign adc_sck_o         = sck_q;
    assign conv.busy         = (state_q == S_CONV) | (state_q == S_SHIFT);
    assign conv.result       = shift_q;
    assign conv.result_valid = (state_q == S_DONE);

endmodule

`default_nettype wire

/* hdl/acq_ctrl.sv */
/*
 * acquisition control, voltage or software CDS mode
 * mode_i is only taken while stopped (ST_IDLE)
 * a request is skipped when the converter is busy or the output slot is full
 * and not accepted that cycle, each skip counts once, counter saturates at 255
 * a skipped first CDS strobe silently drops the second strobe of its pair
 * sample_o/sample_valid_o hold until valid and ready are both high
 */
`timescale 1ns/1ns
`default_nettype none

module acq_ctrl (
    input  logic                   adc_sm_clk,
    input  logic                   adc_sm_rst,
    input  logic                   start_meas_i,
    input  adc_acq_pkg::acq_mode_e mode_i,
    input  logic                   frame_req_i,
    input  logic                   cds_req_i,
    input  logic                   cds_second_i,
    input  logic                   sample_ready_i,
    output adc_acq_pkg::sample_t   sample_o,
    output logic                   sample_valid_o,
    output adc_acq_pkg::ovr_cnt_t  overrun_cnt_o,
    adc_conv_if.ctrl               conv
);
    import adc_acq_pkg::*;

    acq_state_e state_q;
    acq_mode_e  mode_q;         // latched in ST_IDLE
    logic       pair_live_q;    // first strobe of this pair was converted
    logic       valid_q;
    ovr_cnt_t   ovr_q;
    sample_t    cds1_q;
    sample_t    cds2_q;
    sample_t    sample_q;

    logic running;
    logic cds_first;
    logic cand;                 // request wanting a conversion this cycle
    logic slot_free;
    logic accept;
    logic skip;
    logic first_accept;
    logic conv_idle;
    logic load;

    assign running   = (state_q != ST_IDLE) & start_meas_i;
    assign cds_first = cds_req_i & ~cds_second_i;
    assign cand      = running & ((mode_q == ACQ_VOLT) ? frame_req_i
                                  : (cds_first | (cds_req_i & pair_live_q)));
    assign slot_free = ~valid_q | sample_ready_i;    // empty or draining now
    assign accept    = cand & ~conv.busy & slot_free;
    assign skip      = cand & ~accept;
    assign first_accept = accept & (mode_q == ACQ_CDS) & ~cds_second_i;
    assign conv_idle = ~start_meas_i & ~conv.busy;   // stopped and nothing in flight
    assign load      = ((state_q == ST_VOLT) & conv.result_valid) | (state_q == ST_CDS_SUB);

    assign conv.start = accept;

    always_ff @(posedge adc_sm_clk) begin
        if (adc_sm_rst) begin
            state_q     <= ST_IDLE;
            mode_q      <= ACQ_VOLT;
            pair_live_q <= 1'b0;
        end else begin
            if (state_q == ST_IDLE) begin
                pair_live_q <= 1'b0;
            end else if (running && mode_q == ACQ_CDS && cds_req_i) begin
                pair_live_q <= cds_second_i ? 1'b0 : accept;    // second closes the pair
            end

            case (state_q)
                ST_IDLE: begin
                    mode_q <= mode_i;
                    if (start_meas_i) begin
                        state_q <= (mode_i == ACQ_CDS) ? ST_CDS_FIRST : ST_VOLT;
                    end
                end
                ST_VOLT: begin
                    if (conv_idle) state_q <= ST_IDLE;
                end
                ST_CDS_FIRST: begin
                    // a new first strobe on the same cycle means that result is stale
                    if (conv.result_valid && !first_accept) state_q <= ST_CDS_SECOND;
                    else if (conv_idle) state_q <= ST_IDLE;
                end
                ST_CDS_SECOND: begin
                    if (conv.result_valid) state_q <= ST_CDS_SUB;
                    else if (first_accept) state_q <= ST_CDS_FIRST;    // second was lost
                    else if (conv_idle) state_q <= ST_IDLE;
                end
                ST_CDS_SUB: begin
                    state_q <= conv_idle ? ST_IDLE : ST_CDS_FIRST;
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // output slot and overrun count
    always_ff @(posedge adc_sm_clk) begin
        if (adc_sm_rst) begin
            valid_q <= 1'b0;
            ovr_q   <= '0;
        end else begin
            if (load) valid_q <= 1'b1;            // slot is always free here
            else if (sample_ready_i) valid_q <= 1'b0;
            if (skip && ovr_q != '1) begin
                ovr_q <= ovr_q + ovr_cnt_t'(1);
            end
        end
    end

    always_ff @(posedge adc_sm_clk) begin
        if (state_q == ST_CDS_FIRST && conv.result_valid) cds1_q <= conv.result;
        if (state_q == ST_CDS_SECOND && conv.result_valid) cds2_q <= conv.result;
        if (state_q == ST_VOLT && conv.result_valid) begin
            sample_q <= conv.result;
        end else if (state_q == ST_CDS_SUB) begin
            sample_q <= cds2_q - cds1_q;          // wraps, read as two's complement
        end
    end

    assign sample_o       = sample_q;
    assign sample_valid_o = valid_q;
    assign overrun_cnt_o  = ovr_q;

endmodule

`default_nettype wire

/* hdl/adc_acq_top.sv */
/*
 * acquisition top level on adc_sm_clk
 * all inputs must already be synchronous to adc_sm_clk
 * adc_sm_rst is synchronous, active high
 * SETTLE_CYCLES delays voltage-mode conversions after each frame, at least 2
 * CONV_CYCLES sets the CNV high time, at least 1
 */
`timescale 1ns/1ns
`default_nettype none

module adc_acq_top #(
    parameter int SETTLE_CYCLES = 160,      // 8 us at 20 MHz
    parameter int CONV_CYCLES   = 45
) (
    input  logic                   adc_sm_clk,
    input  logic                   adc_sm_rst,
    input  logic                   start_meas_i,
    input  adc_acq_pkg::acq_mode_e mode_i,
    input  logic                   int_reset_i,
    input  adc_acq_pkg::period_t   period_i,
    input  adc_acq_pkg::period_t   cds_delay1_i,
    input  adc_acq_pkg::period_t   cds_delay2_i,
    input  logic                   adc_sdo_i,
    input  logic                   sample_ready_i,
    output logic                   adc_cnv_o,
    output logic                   adc_sck_o,
    output adc_acq_pkg::sample_t   sample_o,
    output logic                   sample_valid_o,
    output adc_acq_pkg::ovr_cnt_t  overrun_cnt_o
);

    logic frame_req;     // settled voltage-mode request
    logic cds_req;
    logic cds_second;

    adc_conv_if conv_bus ();

    sample_timer #(
        .SETTLE_CYCLES (SETTLE_CYCLES)
    ) u_sample_timer (
        .adc_sm_clk   (adc_sm_clk),
        .adc_sm_rst   (adc_sm_rst),
        .start_meas_i (start_meas_i),
        .int_reset_i  (int_reset_i),
        .period_i     (period_i),
        .frame_req_o  (frame_req)
    );

    cds_strobe_gen u_cds_strobe_gen (
        .adc_sm_clk   (adc_sm_clk),
        .adc_sm_rst   (adc_sm_rst),
        .int_reset_i  (int_reset_i),
        .cds_delay1_i (cds_delay1_i),
        .cds_delay2_i (cds_delay2_i),
        .cds_req_o    (cds_req),
        .cds_second_o (cds_second)
    );

    acq_ctrl u_acq_ctrl (
        .adc_sm_clk     (adc_sm_clk),
        .adc_sm_rst     (adc_sm_rst),
        .start_meas_i   (start_meas_i),
        .mode_i         (mode_i),
        .frame_req_i    (frame_req),
        .cds_req_i      (cds_req),
        .cds_second_i   (cds_second),
        .sample_ready_i (sample_ready_i),
        .sample_o       (sample_o),
        .sample_valid_o (sample_valid_o),
        .overrun_cnt_o  (overrun_cnt_o),
        .conv           (conv_bus.ctrl)
    );

    adc_serial_ctrl #(
        .CONV_CYCLES (CONV_CYCLES)
    ) u_adc_serial_ctrl (
        .adc_sm_clk (adc_sm_clk),
        .adc_sm_rst (adc_sm_rst),
        .adc_sdo_i  (adc_sdo_i),
        .adc_cnv_o  (adc_cnv_o),
        .adc_sck_o  (adc_sck_o),
        .conv       (conv_bus.conv)
    );

endmodule

`default_nettype wire

/* test/adc_model.sv */
/*
 * behavioral AD7685-style converter for the testbench
 * value list comes from $random with seed 97, one value per CNV rising edge
 * the MSB sits on SDO from CNV rise, each SCK rise moves to the next bit
 * SDO changes 1 ns after SCK rises, so the DUT samples the old bit
 */
`timescale 1ns/1ns
`default_nettype none

module adc_model #(
    parameter int N_VALUES = 64
) (
    input  logic cnv_i,
    input  logic sck_i,
    output logic sdo_o
);
    logic [15:0] vals [N_VALUES];   // read by the testbench for expected values
    logic [15:0] word;              // word being shifted out
    integer      seed;
    int          conv_idx;
    int          bit_idx;

    initial begin
        seed     = 97;
        conv_idx = 0;
        bit_idx  = 0;
        word     = '0;
        sdo_o    = 1'b0;
        for (int i = 0; i < N_VALUES; i++) begin
            vals[i] = 16'($random(seed));
        end
    end

    always @(posedge cnv_i) begin
        word     = vals[conv_idx % N_VALUES];
        conv_idx = conv_idx + 1;
        bit_idx  = 15;
        sdo_o    = word[15];            // MSB ready before first SCK
    end

    always @(posedge sck_i) begin
        #1;
        if (bit_idx > 0) begin
            bit_idx = bit_idx - 1;
            sdo_o   = word[bit_idx];
        end
    end

endmodule

`default_nettype wire

/* test/tb_adc_acq.sv */
/*
 * directed testbench for adc_acq_top with SETTLE_CYCLES 12, CONV_CYCLES 6
 * inputs change 1 ns after the rising clock, outputs are sampled on the falling clock
 * expected samples come from the converter model's value list
 */
`timescale 1ns/1ns
`default_nettype none

module tb_adc_acq;
    import adc_acq_pkg::*;

    localparam int SETTLE = 12;
    localparam int CONV   = 6;
    localparam int PERIOD = 50;
    localparam int CLK_NS = 4;
    // rough cycle lengths of each test, for the watchdog
    localparam int RUN_CYCLES = 5 + 450 + 480 + 620 + 540 + 400;

    logic      adc_sm_clk;
    logic      adc_sm_rst;
    logic      start_meas;
    acq_mode_e mode;
    logic      int_reset;
    period_t   period;
    period_t   cds_delay1;
    period_t   cds_delay2;
    logic      adc_sdo;
    logic      sample_ready;
    logic      adc_cnv;
    logic      adc_sck;
    sample_t   sample;
    logic      sample_valid;
    ovr_cnt_t  overrun_cnt;

    int      val_errs = 0;
    int      other_errs = 0;
    int      cyc = 0;           // rising edges so far
    int      cnv_count = 0;     // CNV rising edges so far
    int      cnv_cyc[$];        // cycle of each CNV rise
    sample_t got_q[$];          // transferred samples
    logic    cnv_prev = 1'b0;
    logic    prev_hold = 1'b0;
    sample_t prev_sample;

    adc_acq_top #(
        .SETTLE_CYCLES (SETTLE),
        .CONV_CYCLES   (CONV)
    ) UUT (
        .adc_sm_clk     (adc_sm_clk),
        .adc_sm_rst     (adc_sm_rst),
        .start_meas_i   (start_meas),
        .mode_i         (mode),
        .int_reset_i    (int_reset),
        .period_i       (period),
        .cds_delay1_i   (cds_delay1),
        .cds_delay2_i   (cds_delay2),
        .adc_sdo_i      (adc_sdo),
        .sample_ready_i (sample_ready),
        .adc_cnv_o      (adc_cnv),
        .adc_sck_o      (adc_sck),
        .sample_o       (sample),
        .sample_valid_o (sample_valid),
        .overrun_cnt_o  (overrun_cnt)
    );

    adc_model adc_dev (.cnv_i(adc_cnv), .sck_i(adc_sck), .sdo_o(adc_sdo));

    initial begin
        adc_sm_clk = 1'b0;
        forever #(CLK_NS / 2) adc_sm_clk = ~adc_sm_clk;
    end

    always @(posedge adc_sm_clk) cyc <= cyc + 1;

    // output monitor on the falling edge, where everything is stable
    always @(negedge adc_sm_clk) begin
        if (!adc_sm_rst) begin
            if (adc_cnv && !cnv_prev) begin
                cnv_count++;
                cnv_cyc.push_back(cyc);
            end
            if (prev_hold && (!sample_valid || sample !== prev_sample)) begin
                other_errs++;
                $display("sample output dropped or changed while held at cycle %0d", cyc);
            end
            if (sample_valid && sample_ready) got_q.push_back(sample);
            prev_hold   = sample_valid && !sample_ready;
            prev_sample = sample;
        end
        cnv_prev = adc_cnv;
    end

    initial begin
        #(RUN_CYCLES * CLK_NS);
        $display("watchdog: the tests did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic step(input int n);
        repeat (n) @(posedge adc_sm_clk);
        #1;
    endtask

    task automatic pulse_int_reset();
        int_reset = 1'b1;
        step(2);
        int_reset = 1'b0;
    endtask

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            val_errs++;
            $display("error %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic wait_samples(input string name, input int n);
        int k;
        k = 0;
        while (got_q.size() < n && k < 200) begin
            step(1);
            k++;
        end
        if (got_q.size() < n) begin
            other_errs++;
            $display("%s: only %0d of %0d samples arrived", name, got_q.size(), n);
        end
    endtask

    task automatic check_outputs_low(input string name);
        check_val(name, 0, adc_cnv);
        check_val(name, 0, adc_sck);
        check_val(name, 0, sample_valid);
        check_val(name, 0, overrun_cnt);
    endtask

    task automatic test_reset();
        adc_sm_rst = 1'b1;
        repeat (3) begin
            step(1);
            check_outputs_low("reset");
        end
        adc_sm_rst = 1'b0;
        step(1);
        check_outputs_low("after reset");
    endtask

    task automatic test_voltage();
        int base;
        int t0;
        base = cnv_count;
        got_q.delete();
        cnv_cyc.delete();
        mode = ACQ_VOLT;
        sample_ready = 1'b1;
        start_meas = 1'b1;
        step(2);
        t0 = cyc;
        pulse_int_reset();
        step(148);
        pulse_int_reset();
        step(118);                         // stop after the sixth request
        start_meas = 1'b0;
        wait_samples("voltage", 6);
        step(80);
        check_val("voltage sample count", 6, got_q.size());
        for (int k = 0; k < 6 && k < got_q.size(); k++) begin
            check_val("voltage sample", adc_dev.vals[base + k], got_q[k]);
        end
        check_val("voltage cnv count", 6, cnv_cyc.size());
        if (cnv_cyc.size() > 0) check_val("voltage first cnv delay", SETTLE + 2, cnv_cyc[0] - t0);
        for (int k = 1; k < cnv_cyc.size(); k++) begin
            check_val("voltage cnv spacing", PERIOD, cnv_cyc[k] - cnv_cyc[k - 1]);
        end
    endtask

    task automatic test_cds();
        int base;
        sample_t diff;
        base = cnv_count;
        got_q.delete();
        mode = ACQ_CDS;                    // changed while stopped
        step(2);
        start_meas = 1'b1;
        step(2);
        repeat (3) begin
            pulse_int_reset();
            step(118);
        end
        start_meas = 1'b0;
        wait_samples("cds", 3);
        step(80);
        check_val("cds sample count", 3, got_q.size());
        for (int k = 0; k < 3 && k < got_q.size(); k++) begin
            diff = adc_dev.vals[base + 2 * k + 1] - adc_dev.vals[base + 2 * k];
            check_val("cds difference", diff, got_q[k]);
        end
        check_val("cds cnv count", 6, cnv_count - base);
    endtask

    task automatic test_backpressure();
        int base;
        int ovr0;
        base = cnv_count;
        ovr0 = overrun_cnt;
        got_q.delete();
        mode = ACQ_VOLT;
        sample_ready = 1'b0;
        step(2);
        start_meas = 1'b1;
        step(2);
        pulse_int_reset();
        step(148);
        pulse_int_reset();
        step(118);
        start_meas = 1'b0;
        step(80);
        check_val("backpressure overrun count", 5, overrun_cnt - ovr0);
        check_val("backpressure cnv count", 1, cnv_count - base);
        check_val("backpressure held valid", 1, sample_valid);   // first result still waiting
        check_val("backpressure held sample", adc_dev.vals[base], sample);
        sample_ready = 1'b1;
        wait_samples("backpressure held", 1);
        start_meas = 1'b1;
        step(2);
        pulse_int_reset();
        step(68);
        start_meas = 1'b0;
        wait_samples("backpressure resume", 3);
        step(80);
        for (int k = 0; k < 3 && k < got_q.size(); k++) begin
            check_val("backpressure sample", adc_dev.vals[base + k], got_q[k]);
        end
    endtask

    task automatic test_stop();
        int base;
        int n;
        base = cnv_count;
        got_q.delete();
        mode = ACQ_VOLT;
        step(2);
        start_meas = 1'b1;
        step(2);
        pulse_int_reset();
        step(3);
        mode = ACQ_CDS;                    // ignored until the next start
        step(65);
        start_meas = 1'b0;
        wait_samples("stop", 2);
        step(80);
        check_val("stop sample count", 2, got_q.size());
        for (int k = 0; k < 2 && k < got_q.size(); k++) begin
            check_val("stop raw sample", adc_dev.vals[base + k], got_q[k]);
        end
        n = cnv_count;
        pulse_int_reset();
        step(148);
        pulse_int_reset();
        step(148);
        check_val("stop cnv after stop", n, cnv_count);
        check_val("stop samples after stop", 2, got_q.size());
        mode = ACQ_VOLT;
    endtask

    initial begin
        adc_sm_rst   = 1'b1;
        start_meas   = 1'b0;
        mode         = ACQ_VOLT;
        int_reset    = 1'b0;
        period       = period_t'(PERIOD);
        cds_delay1   = period_t'(5);
        cds_delay2   = period_t'(45);
        sample_ready = 1'b1;
        test_reset();
        test_voltage();
        test_cds();
        test_backpressure();
        test_stop();
        $display("errors: %0d wrong values, %0d other failures", val_errs, other_errs);
        if (val_errs == 0 && other_errs == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
hdl/adc_acq_pkg.sv
hdl/adc_conv_if.sv
hdl/sample_timer.sv
hdl/cds_strobe_gen.sv
hdl/adc_serial_ctrl.sv
hdl/acq_ctrl.sv
hdl/adc_acq_top.sv
test/adc_model.sv
test/tb_adc_acq.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_adc_acq
FILELIST   ?= compile.f
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^SIMULATION PASSED$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
